//--- design/mm_pkg.sv
package mm_pkg;

  localparam int vaddr_w    = 48;
  localparam int paddr_w    = 40;
  localparam int page_off_w = 12;
  localparam int word_w     = 64;
  localparam int byte_off_w = 3;                       // Byte within a doubleword
  localparam int regno_w    = 5;

  localparam int vpn_w = vaddr_w - page_off_w;         // 36
  localparam int ppn_w = paddr_w - page_off_w;         // 28

  typedef logic [vpn_w-1:0]  vpn_t;
  typedef logic [ppn_w-1:0]  ppn_t;                    // TLB payload
  typedef logic [word_w-1:0] word_t;                   // Cache payload

  typedef enum logic [3:0] {
    op_none,
    op_lb,
    op_lbu,
    op_lh,
    op_lhu,
    op_lw,
    op_lwu,
    op_ld,
    op_sb,
    op_sh,
    op_sw,
    op_sd
  } mem_op_e;

  typedef enum logic [1:0] {
    fault_none,
    fault_tlb_miss,
    fault_misaligned
  } fault_e;

  function automatic logic op_is_load(input mem_op_e op);
    return op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwu, op_ld};
  endfunction

  function automatic logic op_is_store(input mem_op_e op);
    return op inside {op_sb, op_sh, op_sw, op_sd};
  endfunction

  // Access size in bytes, 8 for anything wider than a word
  function automatic logic [3:0] op_size(input mem_op_e op);
    case (op)
      op_lb, op_lbu, op_sb: return 4'd1;
      op_lh, op_lhu, op_sh: return 4'd2;
      op_lw, op_lwu, op_sw: return 4'd4;
      default:              return 4'd8;
    endcase
  endfunction

endpackage

//--- design/tagged_array.sv
`timescale 1ns/1ps

// Direct-mapped valid/tag/payload store with one read and one write port
module tagged_array #(
  parameter type payload_t = logic [63:0],
  parameter int  depth     = 16,
  parameter int  tag_w     = 8,
  localparam int idx_w     = $clog2(depth)
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             rd_en,
  input  logic [idx_w-1:0] rd_index,
  input  logic             wr_en,
  input  logic [idx_w-1:0] wr_index,
  input  logic [tag_w-1:0] wr_tag,
  input  payload_t         wr_payload,
  output logic             rd_valid,
  output logic [tag_w-1:0] rd_tag,
  output payload_t         rd_payload
);

  logic [depth-1:0] valid_q;
  logic [tag_w-1:0] tag_mem [depth];
  payload_t         payload_mem [depth];

  logic fwd;

  assign fwd = wr_en && (wr_index == rd_index); // Write lands on the line being read

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
    end else if (wr_en) begin
      valid_q[wr_index] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      tag_mem[wr_index]     <= wr_tag;
      payload_mem[wr_index] <= wr_payload;
    end
  end

  // Read valid is control state, cleared with the array
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_valid <= 1'b0;
    end else if (rd_en) begin
      rd_valid <= fwd ? 1'b1 : valid_q[rd_index];
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      if (fwd) begin
        rd_tag     <= wr_tag;        // Bypass the array
        rd_payload <= wr_payload;
      end else begin
        rd_tag     <= tag_mem[rd_index];
        rd_payload <= payload_mem[rd_index];
      end
    end
  end

endmodule

//--- design/mm_control.sv
`timescale 1ns/1ps

module mm_control import mm_pkg::*; #(
  parameter int  tlb_entries = 8,
  parameter int  cache_lines = 16,
  localparam int tlb_idx_w   = $clog2(tlb_entries),
  localparam int tlb_tag_w   = vpn_w - tlb_idx_w,
  localparam int cache_idx_w = $clog2(cache_lines),
  localparam int cache_tag_w = paddr_w - byte_off_w - cache_idx_w
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   flush,
  input  logic                   in_valid,
  input  mem_op_e                in_op,
  input  logic [vaddr_w-1:0]     in_vaddr,
  input  word_t                  in_store_data,
  input  logic [regno_w-1:0]     in_rd,
  input  logic                   in_update_rd,
  input  logic                   tlb_fill,
  input  vpn_t                   tlb_fill_vpn,
  input  ppn_t                   tlb_fill_ppn,
  input  word_t                  mem_rdata,
  input  logic                   mem_done,
  input  logic                   tlb_valid,
  input  logic [tlb_tag_w-1:0]   tlb_tag,
  input  ppn_t                   tlb_ppn,
  input  logic                   cache_valid,
  input  logic [cache_tag_w-1:0] cache_tag,
  input  word_t                  cache_word,
  output logic                   tlb_wr_en,
  output logic [tlb_idx_w-1:0]   tlb_wr_index,
  output logic [tlb_tag_w-1:0]   tlb_wr_tag,
  output ppn_t                   tlb_wr_ppn,
  output logic                   cache_wr_en,
  output logic [cache_idx_w-1:0] cache_wr_index,
  output logic [cache_tag_w-1:0] cache_wr_tag,
  output word_t                  cache_wr_word,
  output logic                   busy,
  output logic                   out_valid,
  output mem_op_e                out_op,
  output logic [regno_w-1:0]     out_rd,
  output logic                   out_update_rd,
  output word_t                  out_data,
  output fault_e                 out_fault,
  output logic                   mem_rd,
  output logic                   mem_wr,
  output logic [paddr_w-1:0]     mem_addr,
  output word_t                  mem_wdata,
  output logic [7:0]             mem_wstrb
);

  typedef enum logic [2:0] {
    st_idle,
    st_lookup,
    st_issue,
    st_wait,
    st_done
  } state_e;

  state_e state_q;
  logic   cancel_q;                      // Flushed while memory was busy

  // Instruction held for the duration of the access
  mem_op_e            op_q;
  logic [vaddr_w-1:0] vaddr_q;
  word_t              store_data_q;
  logic [regno_w-1:0] rd_q;
  logic               update_rd_q;
  fault_e             fault_q;
  logic               hit_q;
  logic [paddr_w-1:0] paddr_q;
  word_t              line_q;            // Hit line or refill data

  logic               tlb_hit;
  logic               cache_hit;
  logic               misaligned;
  logic [3:0]         align_mask;
  logic [paddr_w-1:0] lookup_paddr;
  fault_e             lookup_fault;
  logic [5:0]         bit_shift;
  word_t              wdata;
  word_t              merged;
  word_t              load_raw;
  word_t              load_data;
  logic               store_wr;
  logic               refill_wr;

  // TLB fill replaces whatever the low vpn bits index
  assign tlb_wr_en    = tlb_fill;
  assign tlb_wr_index = tlb_fill_vpn[tlb_idx_w-1:0];
  assign tlb_wr_tag   = tlb_fill_vpn[vpn_w-1:tlb_idx_w];
  assign tlb_wr_ppn   = tlb_fill_ppn;

  // Lookup cycle: translate, then compare with the physical tag
  assign tlb_hit      = tlb_valid && (tlb_tag == vaddr_q[vaddr_w-1:page_off_w+tlb_idx_w]);
  assign lookup_paddr = {tlb_ppn, vaddr_q[page_off_w-1:0]};
  assign cache_hit    = tlb_hit && cache_valid &&
                        (cache_tag == lookup_paddr[paddr_w-1:byte_off_w+cache_idx_w]);
  assign align_mask   = op_size(op_q) - 4'd1;
  assign misaligned   = |(vaddr_q[byte_off_w-1:0] & align_mask[byte_off_w-1:0]);

  always_comb begin
    lookup_fault = fault_none;
    if (misaligned) begin
      lookup_fault = fault_misaligned;   // Checked before translation
    end else if (!tlb_hit) begin
      lookup_fault = fault_tlb_miss;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q  <= st_idle;
      cancel_q <= 1'b0;
    end else begin
      case (state_q)
        st_idle: begin
          if (in_valid) begin
            cancel_q <= 1'b0;
            if (op_is_load(in_op) || op_is_store(in_op)) begin
              state_q <= st_lookup;
            end else begin
              state_q <= st_done;        // Nothing to access
            end
          end
        end
        st_lookup: begin
          if (flush) begin
            state_q <= st_idle;
          end else if (lookup_fault != fault_none || (op_is_load(op_q) && cache_hit)) begin
            state_q <= st_done;
          end else begin
            state_q <= st_issue;         // Load miss or any store
          end
        end
        st_issue: begin
          if (flush) begin
            state_q <= st_idle;          // Strobe was held off
          end else begin
            state_q <= st_wait;
          end
        end
        st_wait: begin
          if (flush) begin
            cancel_q <= 1'b1;
          end
          if (mem_done) begin
            state_q <= st_done;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == st_idle && in_valid) begin
      op_q         <= in_op;
      vaddr_q      <= in_vaddr;
      store_data_q <= in_store_data;
      rd_q         <= in_rd;
      update_rd_q  <= in_update_rd;
      fault_q      <= fault_none;
      hit_q        <= 1'b0;
    end
    if (state_q == st_lookup) begin
      fault_q <= lookup_fault;
      hit_q   <= cache_hit;
      paddr_q <= lookup_paddr;
      line_q  <= cache_word;
    end
    if (state_q == st_wait && mem_done && op_is_load(op_q)) begin
      line_q <= mem_rdata;
    end
  end

  // Store byte lanes
  assign bit_shift = {vaddr_q[byte_off_w-1:0], 3'b000};
  assign wdata     = store_data_q << bit_shift;

  always_comb begin
    case (op_size(op_q))
      4'd1:    mem_wstrb = 8'h01 << vaddr_q[byte_off_w-1:0];
      4'd2:    mem_wstrb = 8'h03 << vaddr_q[byte_off_w-1:0];
      4'd4:    mem_wstrb = 8'h0f << vaddr_q[byte_off_w-1:0];
      default: mem_wstrb = 8'hff;
    endcase
  end

  always_comb begin
    for (int i = 0; i < 8; i++) begin
      merged[8*i +: 8] = mem_wstrb[i] ? wdata[8*i +: 8] : line_q[8*i +: 8];
    end
  end

  // Load alignment and extension
  always_comb begin
    load_raw = line_q >> bit_shift;
    case (op_q)
      op_lb:   load_data = {{56{load_raw[7]}}, load_raw[7:0]};
      op_lbu:  load_data = {56'd0, load_raw[7:0]};
      op_lh:   load_data = {{48{load_raw[15]}}, load_raw[15:0]};
      op_lhu:  load_data = {48'd0, load_raw[15:0]};
      op_lw:   load_data = {{32{load_raw[31]}}, load_raw[31:0]};
      op_lwu:  load_data = {32'd0, load_raw[31:0]};
      op_ld:   load_data = load_raw;
      default: load_data = '0;
    endcase
  end

  // Store hit updates the line in the issue cycle, refill lands with the result
  assign store_wr  = state_q == st_issue && op_is_store(op_q) && hit_q && !flush;
  assign refill_wr = state_q == st_done && op_is_load(op_q) && fault_q == fault_none &&
                     !hit_q && !cancel_q && !flush;

  assign cache_wr_en    = store_wr || refill_wr;
  assign cache_wr_index = vaddr_q[byte_off_w +: cache_idx_w];
  assign cache_wr_tag   = paddr_q[paddr_w-1:byte_off_w+cache_idx_w];
  assign cache_wr_word  = store_wr ? merged : line_q;

  assign mem_rd    = state_q == st_issue && op_is_load(op_q) && !flush;
  assign mem_wr    = state_q == st_issue && op_is_store(op_q) && !flush;
  assign mem_addr  = {paddr_q[paddr_w-1:byte_off_w], {byte_off_w{1'b0}}};
  assign mem_wdata = wdata;

  assign busy          = state_q != st_idle;
  assign out_valid     = state_q == st_done && !cancel_q && !flush;
  assign out_op        = op_q;
  assign out_rd        = rd_q;
  assign out_update_rd = update_rd_q;
  assign out_fault     = fault_q;
  assign out_data      = (fault_q == fault_none) ? load_data : '0;

endmodule

//--- design/mm_stage.sv
`timescale 1ns/1ps

// Memory-access stage: TLB and VIPT cache looked up side by side
module mm_stage import mm_pkg::*; #(
  parameter int  tlb_entries = 8,
  parameter int  cache_lines = 16,          // At most 512 so the index stays in the page
  localparam int tlb_idx_w   = $clog2(tlb_entries),
  localparam int tlb_tag_w   = vpn_w - tlb_idx_w,
  localparam int cache_idx_w = $clog2(cache_lines),
  localparam int cache_tag_w = paddr_w - byte_off_w - cache_idx_w
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               flush,
  input  logic               in_valid,
  input  mem_op_e            in_op,
  input  logic [vaddr_w-1:0] in_vaddr,
  input  word_t              in_store_data,
  input  logic [regno_w-1:0] in_rd,
  input  logic               in_update_rd,
  output logic               busy,
  output logic               out_valid,
  output mem_op_e            out_op,
  output logic [regno_w-1:0] out_rd,
  output logic               out_update_rd,
  output word_t              out_data,
  output fault_e             out_fault,
  input  logic               tlb_fill,
  input  vpn_t               tlb_fill_vpn,
  input  ppn_t               tlb_fill_ppn,
  output logic               mem_rd,
  output logic               mem_wr,
  output logic [paddr_w-1:0] mem_addr,
  output word_t              mem_wdata,
  output logic [7:0]         mem_wstrb,
  input  word_t              mem_rdata,
  input  logic               mem_done
);

  logic                   lookup_en;
  logic [tlb_idx_w-1:0]   tlb_rd_index;
  logic [cache_idx_w-1:0] cache_rd_index;

  logic                   tlb_valid;
  logic [tlb_tag_w-1:0]   tlb_tag;
  ppn_t                   tlb_ppn;
  logic                   tlb_wr_en;
  logic [tlb_idx_w-1:0]   tlb_wr_index;
  logic [tlb_tag_w-1:0]   tlb_wr_tag;
  ppn_t                   tlb_wr_ppn;

  logic                   cache_valid;
  logic [cache_tag_w-1:0] cache_tag;
  word_t                  cache_word;
  logic                   cache_wr_en;
  logic [cache_idx_w-1:0] cache_wr_index;
  logic [cache_tag_w-1:0] cache_wr_tag;
  word_t                  cache_wr_word;

  assign lookup_en      = in_valid && !busy;                        // Only an accepted op reads
  assign tlb_rd_index   = in_vaddr[page_off_w +: tlb_idx_w];        // Low vpn bits
  assign cache_rd_index = in_vaddr[byte_off_w +: cache_idx_w];      // Inside the page offset

  tagged_array #(
    .payload_t (ppn_t),
    .depth     (tlb_entries),
    .tag_w     (tlb_tag_w)
  ) tlb0 (
    .clk        (clk),
    .reset      (reset),
    .rd_en      (lookup_en),
    .rd_index   (tlb_rd_index),
    .wr_en      (tlb_wr_en),
    .wr_index   (tlb_wr_index),
    .wr_tag     (tlb_wr_tag),
    .wr_payload (tlb_wr_ppn),
    .rd_valid   (tlb_valid),
    .rd_tag     (tlb_tag),
    .rd_payload (tlb_ppn)
  );

  tagged_array #(
    .payload_t (word_t),
    .depth     (cache_lines),
    .tag_w     (cache_tag_w)
  ) cache0 (
    .clk        (clk),
    .reset      (reset),
    .rd_en      (lookup_en),
    .rd_index   (cache_rd_index),
    .wr_en      (cache_wr_en),
    .wr_index   (cache_wr_index),
    .wr_tag     (cache_wr_tag),
    .wr_payload (cache_wr_word),
    .rd_valid   (cache_valid),
    .rd_tag     (cache_tag),
    .rd_payload (cache_word)
  );

  mm_control #(
    .tlb_entries (tlb_entries),
    .cache_lines (cache_lines)
  ) ctrl0 (
    .clk            (clk),
    .reset          (reset),
    .flush          (flush),
    .in_valid       (in_valid),
    .in_op          (in_op),
    .in_vaddr       (in_vaddr),
    .in_store_data  (in_store_data),
    .in_rd          (in_rd),
    .in_update_rd   (in_update_rd),
    .tlb_fill       (tlb_fill),
    .tlb_fill_vpn   (tlb_fill_vpn),
    .tlb_fill_ppn   (tlb_fill_ppn),
    .mem_rdata      (mem_rdata),
    .mem_done       (mem_done),
    .tlb_valid      (tlb_valid),
    .tlb_tag        (tlb_tag),
    .tlb_ppn        (tlb_ppn),
    .cache_valid    (cache_valid),
    .cache_tag      (cache_tag),
    .cache_word     (cache_word),
    .tlb_wr_en      (tlb_wr_en),
    .tlb_wr_index   (tlb_wr_index),
    .tlb_wr_tag     (tlb_wr_tag),
    .tlb_wr_ppn     (tlb_wr_ppn),
    .cache_wr_en    (cache_wr_en),
    .cache_wr_index (cache_wr_index),
    .cache_wr_tag   (cache_wr_tag),
    .cache_wr_word  (cache_wr_word),
    .busy           (busy),
    .out_valid      (out_valid),
    .out_op         (out_op),
    .out_rd         (out_rd),
    .out_update_rd  (out_update_rd),
    .out_data       (out_data),
    .out_fault      (out_fault),
    .mem_rd         (mem_rd),
    .mem_wr         (mem_wr),
    .mem_addr       (mem_addr),
    .mem_wdata      (mem_wdata),
    .mem_wstrb      (mem_wstrb)
  );

endmodule

//--- test/mm_stage_checker.sv
`timescale 1ns/1ps

// Strobe and busy rules on the stage boundary
module mm_stage_checker (
  input logic clk,
  input logic reset,
  input logic in_valid,
  input logic busy,
  input logic out_valid,
  input logic mem_rd,
  input logic mem_wr
);

  a_rd_wr_excl: assert property (@(posedge clk) disable iff (reset)
    !(mem_rd && mem_wr))
    else $error("mem_rd and mem_wr high together");

  a_rd_pulse: assert property (@(posedge clk) disable iff (reset)
    mem_rd |=> !mem_rd)
    else $error("mem_rd longer than one cycle");

  a_wr_pulse: assert property (@(posedge clk) disable iff (reset)
    mem_wr |=> !mem_wr)
    else $error("mem_wr longer than one cycle");

  a_out_vs_accept: assert property (@(posedge clk) disable iff (reset)
    (in_valid && !busy) |-> !out_valid)
    else $error("out_valid while a new instruction is accepted");

  a_no_in_when_busy: assert property (@(posedge clk) disable iff (reset)
    in_valid |-> !busy)
    else $error("in_valid while busy");

  a_free_after_out: assert property (@(posedge clk) disable iff (reset)
    out_valid |=> !busy)
    else $error("busy still high after out_valid");

endmodule

bind mm_stage mm_stage_checker chk0 (
  .clk       (clk),
  .reset     (reset),
  .in_valid  (in_valid),
  .busy      (busy),
  .out_valid (out_valid),
  .mem_rd    (mem_rd),
  .mem_wr    (mem_wr)
);

//--- test/mm_stage_tb.sv
`timescale 1ns/1ps

module mm_stage_tb import mm_pkg::*; ();

  localparam int tlb_n       = 8;
  localparam int cache_n     = 16;
  localparam int max_ops     = 220;               // Upper bound on operations and fills issued
  localparam int op_cycles   = 16;                // Worst case per operation incl. memory delay
  localparam int cycle_limit = max_ops * op_cycles + 50;

  logic               clk;
  logic               reset;
  logic               flush;
  logic               in_valid;
  mem_op_e            in_op;
  logic [vaddr_w-1:0] in_vaddr;
  word_t              in_store_data;
  logic [regno_w-1:0] in_rd;
  logic               in_update_rd;
  logic               busy;
  logic               out_valid;
  mem_op_e            out_op;
  logic [regno_w-1:0] out_rd;
  logic               out_update_rd;
  word_t              out_data;
  fault_e             out_fault;
  logic               tlb_fill;
  vpn_t               tlb_fill_vpn;
  ppn_t               tlb_fill_ppn;
  logic               mem_rd;
  logic               mem_wr;
  logic [paddr_w-1:0] mem_addr;
  word_t              mem_wdata;
  logic [7:0]         mem_wstrb;
  word_t              mem_rdata;
  logic               mem_done;

  mm_stage #(
    .tlb_entries (tlb_n),
    .cache_lines (cache_n)
  ) dut0 (.*);

  // Random state, one stream for stimulus and one for the memory responder
  logic [31:0] seed      = 32'd18633;
  logic [31:0] resp_seed = 32'd18633 ^ 32'h0000_5a5a;

  int    cyc = 0;
  int    errors = 0;
  int    checks = 0;
  int    tests_run = 0;
  int    tests_failed = 0;
  int    test_err_start;
  string cur_test;

  // Reference model state
  word_t              model_mem [logic [paddr_w-1:0]];
  word_t              resp_mem [logic [paddr_w-1:0]];
  logic               tlb_v [tlb_n];
  vpn_t               tlb_vpn [tlb_n];
  ppn_t               tlb_ppn_m [tlb_n];
  logic               c_v [cache_n];
  logic [32:0]        c_tag [cache_n];             // paddr bits 39:7
  word_t              c_word [cache_n];

  // Values seen on the DUT ports during one operation
  int                 acc_cyc;
  int                 out_cyc;
  int                 done_cyc;
  int                 rd_cyc;
  int                 wr_cyc;
  int                 rd_cnt;
  int                 wr_cnt;
  int                 out_cnt;
  logic [paddr_w-1:0] rd_addr;
  logic [paddr_w-1:0] wr_addr;
  logic [7:0]         wr_strb;
  word_t              wr_data;
  word_t              out_data_s;
  fault_e             out_fault_s;
  mem_op_e            out_op_s;
  logic [regno_w-1:0] out_rd_s;
  logic               out_upd_s;

  int                 pend_cnt;
  logic [paddr_w-1:0] pend_addr;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function logic [15:0] rand16();
    seed = lcg_step(seed);
    return seed[31:16];
  endfunction

  function logic [63:0] rand64();
    return {rand16(), rand16(), rand16(), rand16()};
  endfunction

  // Untouched memory reads back a pattern of its own address
  function automatic word_t fill_word(input logic [paddr_w-1:0] a);
    return {a[39:8] ^ 32'h5a5a_1234, a[31:0] ^ 32'hc3a5_0f96};
  endfunction

  function automatic word_t model_read(input logic [paddr_w-1:0] a);
    return model_mem.exists(a) ? model_mem[a] : fill_word(a);
  endfunction

  function automatic logic is_load(input mem_op_e op);
    return op >= op_lb && op <= op_ld;
  endfunction

  function automatic logic is_store(input mem_op_e op);
    return op >= op_sb && op <= op_sd;
  endfunction

  function automatic int size_of(input mem_op_e op);
    case (op)
      op_lb, op_lbu, op_sb: return 1;
      op_lh, op_lhu, op_sh: return 2;
      op_lw, op_lwu, op_sw: return 4;
      default:              return 8;
    endcase
  endfunction

  function automatic word_t extend_load(input mem_op_e op, input word_t line,
                                        input logic [2:0] off);
    word_t sh;
    sh = line >> (8 * off);
    case (op)
      op_lb:   return {{56{sh[7]}}, sh[7:0]};
      op_lbu:  return {56'd0, sh[7:0]};
      op_lh:   return {{48{sh[15]}}, sh[15:0]};
      op_lhu:  return {48'd0, sh[15:0]};
      op_lw:   return {{32{sh[31]}}, sh[31:0]};
      op_lwu:  return {32'd0, sh[31:0]};
      default: return sh;
    endcase
  endfunction

  function automatic word_t merge_bytes(input word_t old, input word_t nw,
                                        input logic [7:0] strb);
    word_t r;
    for (int i = 0; i < 8; i++) begin
      r[8*i +: 8] = strb[i] ? nw[8*i +: 8] : old[8*i +: 8];
    end
    return r;
  endfunction

  function automatic logic model_cache_hit(input logic [vaddr_w-1:0] va);
    int                 ti;
    int                 ci;
    logic [paddr_w-1:0] pa;
    ti = int'(va[14:12]);
    ci = int'(va[6:3]);
    if (!tlb_v[ti] || tlb_vpn[ti] != va[47:12]) return 1'b0;
    pa = {tlb_ppn_m[ti], va[11:0]};
    return c_v[ci] && c_tag[ci] == pa[39:7];
  endfunction

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // Port monitor sampling values from before the edge
  always @(posedge clk) begin
    if (in_valid && !busy) acc_cyc = cyc;
    if (mem_done) done_cyc = cyc;
    if (out_valid) begin
      out_cnt++;
      out_cyc     = cyc;
      out_data_s  = out_data;
      out_fault_s = out_fault;
      out_op_s    = out_op;
      out_rd_s    = out_rd;
      out_upd_s   = out_update_rd;
    end
    if (mem_rd) begin
      rd_cnt++;
      rd_cyc  = cyc;
      rd_addr = mem_addr;
    end
    if (mem_wr) begin
      wr_cnt++;
      wr_cyc  = cyc;
      wr_addr = mem_addr;
      wr_strb = mem_wstrb;
      wr_data = mem_wdata;
    end
  end

  // Memory responder with a random delay of 1 to 4 cycles
  always @(posedge clk) begin
    mem_done <= 1'b0;
    if (reset) begin
      pend_cnt = 0;
    end else if (pend_cnt > 0) begin
      pend_cnt--;
      if (pend_cnt == 0) begin
        mem_done  <= 1'b1;
        mem_rdata <= resp_mem.exists(pend_addr) ? resp_mem[pend_addr] : fill_word(pend_addr);
      end
    end else if (mem_rd || mem_wr) begin
      resp_seed = lcg_step(resp_seed);
      pend_cnt  = int'(resp_seed[17:16]) + 1;
      pend_addr = mem_addr;
      if (mem_wr) begin
        resp_mem[mem_addr] = merge_bytes(
          resp_mem.exists(mem_addr) ? resp_mem[mem_addr] : fill_word(mem_addr),
          mem_wdata, mem_wstrb);
      end
    end
  end

  task automatic check_eq(input string what, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    assert (exp === act) else begin
      errors++;
      $display("mismatch in %s: %s expected %0h actual %0h", cur_test, what, exp, act);
    end
  endtask

  task automatic begin_test(input string name);
    cur_test       = name;
    test_err_start = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors == test_err_start) begin
      $display("test %s: ok", cur_test);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", cur_test, errors - test_err_start);
    end
  endtask

  task automatic fill_tlb(input vpn_t vpn, input ppn_t ppn);
    @(posedge clk);
    tlb_fill     <= 1'b1;
    tlb_fill_vpn <= vpn;
    tlb_fill_ppn <= ppn;
    @(posedge clk);
    tlb_fill <= 1'b0;
    tlb_v[vpn[2:0]]     = 1'b1;                   // Direct mapped on low vpn bits
    tlb_vpn[vpn[2:0]]   = vpn;
    tlb_ppn_m[vpn[2:0]] = ppn;
  endtask

  // flush_at selects no flush (0), flush in lookup (1) or while waiting on memory (2)
  task automatic run_op(input mem_op_e op, input logic [vaddr_w-1:0] va, input word_t sd,
                        input int flush_at);
    int                 ti;
    int                 ci;
    int                 k;
    int                 exit_cyc;
    logic               thit;
    logic               chit;
    logic               misal;
    logic               to_mem;
    logic               exp_out;
    logic               exp_rd;
    logic               exp_wr;
    logic [paddr_w-1:0] pa;
    logic [paddr_w-1:0] da;
    fault_e             efault;
    word_t              line;
    word_t              wdata;
    logic [7:0]         strb;
    logic [regno_w-1:0] rd;
    logic               upd;
    ti     = int'(va[14:12]);
    ci     = int'(va[6:3]);
    misal  = (int'(va[2:0]) % size_of(op)) != 0;
    thit   = tlb_v[ti] && tlb_vpn[ti] == va[47:12];
    pa     = {tlb_ppn_m[ti], va[11:0]};
    da     = {pa[39:3], 3'b000};
    chit   = thit && c_v[ci] && c_tag[ci] == pa[39:7];
    efault = fault_none;
    if (op != op_none && misal) efault = fault_misaligned;
    else if (op != op_none && !thit) efault = fault_tlb_miss;
    strb   = 8'((16'd1 << size_of(op)) - 16'd1) << va[2:0];
    wdata  = sd << (8 * va[2:0]);
    line   = chit ? c_word[ci] : model_read(da);
    to_mem = efault == fault_none && (is_store(op) || (is_load(op) && !chit));
    exp_out = flush_at == 0;
    exp_rd  = flush_at != 1 && is_load(op) && to_mem;
    exp_wr  = flush_at != 1 && is_store(op) && to_mem;
    rd      = 5'(rand16());
    upd     = rand16() >= 16'h8000;
    acc_cyc  = -1;
    done_cyc = -1;
    out_cnt  = 0;
    rd_cnt   = 0;
    wr_cnt   = 0;
    @(posedge clk);
    in_valid      <= 1'b1;
    in_op         <= op;
    in_vaddr      <= va;
    in_store_data <= sd;
    in_rd         <= rd;
    in_update_rd  <= upd;
    @(posedge clk);
    in_valid <= 1'b0;
    flush    <= flush_at == 1;
    k = 0;
    do begin
      @(posedge clk);
      k++;
      flush <= flush_at == 2 && k == 2;
    end while (busy);
    exit_cyc = cyc;
    check_eq("out_valid count", 64'(exp_out), 64'(out_cnt));
    check_eq("mem_rd count", 64'(exp_rd), 64'(rd_cnt));
    check_eq("mem_wr count", 64'(exp_wr), 64'(wr_cnt));
    if (exp_rd && rd_cnt == 1) begin
      check_eq("mem_rd address", 64'(da), 64'(rd_addr));
      check_eq("mem_rd cycle", 64'(acc_cyc + 2), 64'(rd_cyc));
    end
    if (exp_wr && wr_cnt == 1) begin
      check_eq("mem_wr address", 64'(da), 64'(wr_addr));
      check_eq("mem_wr strobe", 64'(strb), 64'(wr_strb));
      check_eq("mem_wr data", wdata, wr_data);
      check_eq("mem_wr cycle", 64'(acc_cyc + 2), 64'(wr_cyc));
    end
    if (exp_out && out_cnt == 1) begin
      check_eq("out_fault", 64'(efault), 64'(out_fault_s));
      check_eq("out_op", 64'(op), 64'(out_op_s));
      check_eq("out_rd", 64'(rd), 64'(out_rd_s));
      check_eq("out_update_rd", 64'(upd), 64'(out_upd_s));
      if (is_load(op) && efault == fault_none) begin
        check_eq("out_data", extend_load(op, line, va[2:0]), out_data_s);
      end
      if (op == op_none) check_eq("out_valid cycle", 64'(acc_cyc + 1), 64'(out_cyc));
      else if (to_mem) check_eq("out_valid cycle", 64'(done_cyc + 1), 64'(out_cyc));
      else check_eq("out_valid cycle", 64'(acc_cyc + 2), 64'(out_cyc));
      check_eq("busy release cycle", 64'(out_cyc + 1), 64'(exit_cyc));
    end
    if (flush_at == 2) begin
      check_eq("busy after mem_done", 64'(done_cyc + 2), 64'(exit_cyc));
    end
    if (flush_at != 1 && efault == fault_none) begin
      if (is_store(op)) begin
        model_mem[da] = merge_bytes(model_read(da), wdata, strb);
        if (chit) c_word[ci] = merge_bytes(c_word[ci], wdata, strb);  // Only a hit is updated
      end else if (is_load(op) && !chit && flush_at == 0) begin
        c_v[ci]    = 1'b1;
        c_tag[ci]  = pa[39:7];
        c_word[ci] = model_read(da);
      end
    end
  endtask

  function automatic logic [vaddr_w-1:0] mapped_addr(input mem_op_e op);
    int         i;
    logic [7:0] off;
    i   = int'(rand16() % 16'(tlb_n));
    off = 8'(rand16()) & ~8'(size_of(op) - 1);    // Small window so lines get reused
    return {tlb_vpn[i], 4'd0, off};
  endfunction

  initial begin
    mem_op_e            op;
    logic [vaddr_w-1:0] va;
    vpn_t               vpn_new;
    word_t              sd;
    int                 tries;
    reset         = 1'b1;
    flush         = 1'b0;
    in_valid      = 1'b0;
    in_op         = op_none;
    in_vaddr      = '0;
    in_store_data = '0;
    in_rd         = '0;
    in_update_rd  = 1'b0;
    tlb_fill      = 1'b0;
    tlb_fill_vpn  = '0;
    tlb_fill_ppn  = '0;
    mem_rdata     = '0;
    mem_done      = 1'b0;
    for (int i = 0; i < tlb_n; i++) tlb_v[i] = 1'b0;
    for (int i = 0; i < cache_n; i++) c_v[i] = 1'b0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;

    begin_test("reset_and_none");
    @(posedge clk);
    check_eq("busy after reset", 64'd0, 64'(busy));
    check_eq("out_valid after reset", 64'd0, 64'(out_valid));
    check_eq("mem_rd after reset", 64'd0, 64'(mem_rd));
    check_eq("mem_wr after reset", 64'd0, 64'(mem_wr));
    for (int n = 0; n < 5; n++) run_op(op_none, 48'(rand64()), rand64(), 0);
    end_test();

    for (int i = 0; i < tlb_n; i++) begin
      fill_tlb({rand16(), rand16(), 1'b0, 3'(i)}, {rand16(), 9'(rand16()), 3'(i)});
    end

    begin_test("faults");
    va = {tlb_vpn[1], 12'h000};
    run_op(op_lh, va + 48'd1, 64'd0, 0);
    run_op(op_lw, va + 48'd2, 64'd0, 0);
    run_op(op_ld, va + 48'd4, 64'd0, 0);
    run_op(op_sh, va + 48'd3, rand64(), 0);
    run_op(op_sw, va + 48'd6, rand64(), 0);
    run_op(op_lhu, va + 48'd5, 64'd0, 0);
    va = {tlb_vpn[1][35:3] ^ 33'h1, 3'd1, 12'h010};  // Right index, wrong page
    run_op(op_ld, va, 64'd0, 0);
    run_op(op_sb, va, rand64(), 0);
    end_test();

    begin_test("loads");
    for (int n = 0; n < 49; n++) begin
      op = mem_op_e'(1 + n % 7);
      run_op(op, mapped_addr(op), 64'd0, 0);
    end
    end_test();

    begin_test("stores");
    for (int n = 0; n < 24; n++) begin
      op = mem_op_e'(8 + n % 4);
      va = mapped_addr(op);
      sd = rand64();
      run_op(op, va, sd, 0);
      run_op(op == op_sb ? op_lbu : op == op_sh ? op_lhu : op == op_sw ? op_lwu : op_ld,
             va, 64'd0, 0);
    end
    end_test();

    begin_test("tlb_replace");
    va = {tlb_vpn[2], 12'h048};
    run_op(op_ld, va, 64'd0, 0);
    run_op(op_ld, va, 64'd0, 0);
    vpn_new = {tlb_vpn[2][35:3] + 33'd1, 3'd2};
    fill_tlb(vpn_new, tlb_ppn_m[2] ^ 28'h100_0000);  // New page, old lines differ in tag
    run_op(op_ld, va, 64'd0, 0);
    run_op(op_lw, {vpn_new, 12'h048}, 64'd0, 0);
    run_op(op_lw, {vpn_new, 12'h048}, 64'd0, 0);
    end_test();

    begin_test("flush");
    tries = 0;
    do begin
      va = mapped_addr(op_ld);
      tries++;
    end while (model_cache_hit(va) && tries < 100);
    checks++;
    assert (!model_cache_hit(va)) else begin
      errors++;
      $display("flush test could not find an address that misses in the cache");
    end
    run_op(op_ld, va, 64'd0, 1);
    run_op(op_sd, va, rand64(), 1);
    run_op(op_ld, va, 64'd0, 2);
    run_op(op_ld, va, 64'd0, 0);                  // Misses again after the cancelled refill
    run_op(op_ld, va, 64'd0, 0);
    end_test();

    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- mm_stage.f
design/mm_pkg.sv
design/tagged_array.sv
design/mm_control.sv
design/mm_stage.sv
test/mm_stage_checker.sv
test/mm_stage_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= mm_stage_tb
FILELIST  ?= mm_stage.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
